//--- test_iterator.f
+incdir+verilog
+incdir+dv
verilog/raster_pkg.sv
verilog/sample_stepper.sv
verilog/bbox_iterator_fsm.sv
verilog/prim_hold_reg.sv
verilog/test_iterator.sv
dv/test_iterator_tb.sv

//--- dv/sample_model.svh
// ------------------------------------------------
// Reference box walk, random words and compare tasks
// Included inside the testbench module body
// Needs stop_with_failure and checks_run declared first
// ------------------------------------------------
`ifndef SAMPLE_MODEL_SVH
`define SAMPLE_MODEL_SVH

// Expected sample list for the box under test
raster_pkg::fixed_t exp_x [$];
raster_pkg::fixed_t exp_y [$];

// LCG state, fixed seed for a repeatable run
logic [31:0] lcg_state = 32'h9100_f44f;

// Numerical Recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// Upper LCG bits are the better ones
function automatic raster_pkg::fixed_t rand_word();
    lcg_state = lcg_next(lcg_state);
    return raster_pkg::fixed_t'(lcg_state[31:8]);
endfunction

// Pitch from the meaning of each mode
function automatic raster_pkg::fixed_t pitch_of(input raster_pkg::sub_sample_t mode);
    raster_pkg::fixed_t one;
    one = raster_pkg::fixed_t'(1 << `RAST_RADIX);
    case (mode)
        4'b1000: return one;
        4'b0100: return one >>> 1;
        4'b0010: return one >>> 2;
        default: return one >>> 3;
    endcase
endfunction

// Left to right, then wrap one row up, until both edges are reached
task automatic build_walk(
    input raster_pkg::fixed_t      min_x,
    input raster_pkg::fixed_t      min_y,
    input raster_pkg::fixed_t      max_x,
    input raster_pkg::fixed_t      max_y,
    input raster_pkg::sub_sample_t mode
);
    raster_pkg::fixed_t x;
    raster_pkg::fixed_t y;
    raster_pkg::fixed_t pitch;
    int                 guard;
    exp_x.delete();
    exp_y.delete();
    pitch = pitch_of(mode);
    x = min_x;
    y = min_y;
    guard = 0;
    exp_x.push_back(x);
    exp_y.push_back(y);
    // Guard keeps a broken table row from looping forever
    while (!(x >= max_x && y >= max_y) && guard < 4096) begin
        if (x >= max_x) begin
            x = min_x;
            y = y + pitch;
        end else begin
            x = x + pitch;
        end
        exp_x.push_back(x);
        exp_y.push_back(y);
        guard++;
    end
endtask

task automatic check_fixed(input string name, input raster_pkg::fixed_t exp,
                           input raster_pkg::fixed_t act);
    checks_run++;
    if (act !== exp) begin
        $display("CHECK FAILED at %0d ns: %s expected %0d got %0d", $time, name, exp, act);
        stop_with_failure();
    end
endtask

task automatic check_color(input string name, input raster_pkg::color_t exp,
                           input raster_pkg::color_t act);
    checks_run++;
    if (act !== exp) begin
        $display("CHECK FAILED at %0d ns: %s expected 0x%h got 0x%h", $time, name, exp, act);
        stop_with_failure();
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    checks_run++;
    if (act !== exp) begin
        $display("CHECK FAILED at %0d ns: %s expected %b got %b", $time, name, exp, act);
        stop_with_failure();
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    checks_run++;
    if (act != exp) begin
        $display("CHECK FAILED at %0d ns: %s expected %0d got %0d", $time, name, exp, act);
        stop_with_failure();
    end
endtask

`endif

//--- dv/test_iterator_tb.sv
// ------------------------------------------------
// Testbench for the raster sample iterator
// Table rows give box, mode and expected columns and rows
// Chained rows are offered in the first idle cycle
// Inputs are scrambled during each walk to prove they are ignored
// ------------------------------------------------
`timescale 1ns/1ps
`include "raster_settings.svh"

module test_iterator_tb;

    localparam int NUM_CASES  = 7;
    // Cycles any single wait may take
    localparam int WAIT_LIMIT = 20;

    logic                    clk;
    logic                    rst;
    raster_pkg::fixed_t      tri_in [`RAST_VERTS-1:0][`RAST_AXIS-1:0];
    raster_pkg::color_t      color_in [`RAST_COLORS-1:0];
    raster_pkg::fixed_t      box_min_x;
    raster_pkg::fixed_t      box_min_y;
    raster_pkg::fixed_t      box_max_x;
    raster_pkg::fixed_t      box_max_y;
    logic                    tri_valid;
    raster_pkg::sub_sample_t sub_sample;
    raster_pkg::fixed_t      tri_out [`RAST_VERTS-1:0][`RAST_AXIS-1:0];
    raster_pkg::color_t      color_out [`RAST_COLORS-1:0];
    raster_pkg::fixed_t      sample_x;
    raster_pkg::fixed_t      sample_y;
    logic                    sample_valid;
    logic                    halt_n;

    // Triangle and colour that the current walk must carry
    raster_pkg::fixed_t      exp_tri [`RAST_VERTS-1:0][`RAST_AXIS-1:0];
    raster_pkg::color_t      exp_color [`RAST_COLORS-1:0];

    // Stimulus table
    raster_pkg::fixed_t      tab_min_x [NUM_CASES];
    raster_pkg::fixed_t      tab_min_y [NUM_CASES];
    raster_pkg::fixed_t      tab_max_x [NUM_CASES];
    raster_pkg::fixed_t      tab_max_y [NUM_CASES];
    raster_pkg::sub_sample_t tab_mode  [NUM_CASES];
    int                      tab_cols  [NUM_CASES];
    int                      tab_rows  [NUM_CASES];
    bit                      tab_chained [NUM_CASES];

    int checks_run = 0;

    test_iterator UUT (
        .clk          (clk),
        .rst          (rst),
        .tri_in       (tri_in),
        .color_in     (color_in),
        .box_min_x    (box_min_x),
        .box_min_y    (box_min_y),
        .box_max_x    (box_max_x),
        .box_max_y    (box_max_y),
        .tri_valid    (tri_valid),
        .sub_sample   (sub_sample),
        .tri_out      (tri_out),
        .color_out    (color_out),
        .sample_x     (sample_x),
        .sample_y     (sample_y),
        .sample_valid (sample_valid),
        .halt_n       (halt_n)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    `include "sample_model.svh"

    // Fixed point from whole pixels plus eighths
    function automatic raster_pkg::fixed_t fx(input int whole, input int eighths);
        return raster_pkg::fixed_t'(whole * (1 << `RAST_RADIX)
                                    + eighths * (1 << (`RAST_RADIX - 3)));
    endfunction

    task automatic set_case(input int idx, input raster_pkg::fixed_t mnx,
                            input raster_pkg::fixed_t mny, input raster_pkg::fixed_t mxx,
                            input raster_pkg::fixed_t mxy, input raster_pkg::sub_sample_t md,
                            input int cols, input int rows, input bit chained);
        tab_min_x[idx]   = mnx;
        tab_min_y[idx]   = mny;
        tab_max_x[idx]   = mxx;
        tab_max_y[idx]   = mxy;
        tab_mode[idx]    = md;
        tab_cols[idx]    = cols;
        tab_rows[idx]    = rows;
        tab_chained[idx] = chained;
    endtask

    task automatic load_table();
        // 1x on a pixel-aligned box
        set_case(0, fx(2, 0), fx(3, 0), fx(5, 0), fx(5, 0), 4'b1000, 4, 3, 1'b0);
        // 4x, negative corners
        set_case(1, fx(-1, 0), fx(-1, 0), fx(0, 0), fx(0, 0), 4'b0100, 3, 3, 1'b0);
        // 16x, max off the quarter grid so the last column and row overshoot
        set_case(2, fx(0, 0), fx(0, 0), fx(0, 5), fx(0, 3), 4'b0010, 4, 3, 1'b0);
        // 64x, taken straight after case 2
        set_case(3, fx(1, 0), fx(1, 0), fx(1, 4), fx(1, 2), 4'b0001, 5, 3, 1'b1);
        // Single sample box
        set_case(4, fx(7, 0), fx(-2, 0), fx(7, 0), fx(-2, 0), 4'b1000, 1, 1, 1'b0);
        // 1x with off-grid negative max x
        set_case(5, fx(-3, 0), fx(0, 0), fx(-2, 4), fx(0, 4), 4'b1000, 3, 2, 1'b0);
        set_case(6, fx(4, 0), fx(4, 0), fx(5, 0), fx(4, 0), 4'b0100, 3, 1, 1'b1);
    endtask

    task automatic init_inputs();
        for (int v = 0; v < `RAST_VERTS; v++) begin
            for (int a = 0; a < `RAST_AXIS; a++) begin
                tri_in[v][a] <= '0;
            end
        end
        for (int k = 0; k < `RAST_COLORS; k++) begin
            color_in[k] <= '0;
        end
        rst        <= 1'b1;
        box_min_x  <= '0;
        box_min_y  <= '0;
        box_max_x  <= '0;
        box_max_y  <= '0;
        tri_valid  <= 1'b0;
        sub_sample <= 4'b1000;
    endtask

    // Drive one table row with fresh triangle and colour words
    task automatic present_case(input int c);
        raster_pkg::fixed_t w;
        for (int v = 0; v < `RAST_VERTS; v++) begin
            for (int a = 0; a < `RAST_AXIS; a++) begin
                w = rand_word();
                tri_in[v][a]  <= w;
                exp_tri[v][a]  = w;
            end
        end
        for (int k = 0; k < `RAST_COLORS; k++) begin
            w = rand_word();
            color_in[k]  <= raster_pkg::color_t'(w);
            exp_color[k]  = raster_pkg::color_t'(w);
        end
        box_min_x  <= tab_min_x[c];
        box_min_y  <= tab_min_y[c];
        box_max_x  <= tab_max_x[c];
        box_max_y  <= tab_max_y[c];
        sub_sample <= tab_mode[c];
        tri_valid  <= 1'b1;
    endtask

    // Garbage on every input except the mode
    task automatic disturb_inputs(input int i);
        for (int v = 0; v < `RAST_VERTS; v++) begin
            for (int a = 0; a < `RAST_AXIS; a++) begin
                tri_in[v][a] <= rand_word();
            end
        end
        for (int k = 0; k < `RAST_COLORS; k++) begin
            color_in[k] <= raster_pkg::color_t'(rand_word());
        end
        box_min_x <= rand_word();
        box_min_y <= rand_word();
        box_max_x <= rand_word();
        box_max_y <= rand_word();
        tri_valid <= (i % 2 == 0);
    endtask

    task automatic check_held();
        for (int v = 0; v < `RAST_VERTS; v++) begin
            for (int a = 0; a < `RAST_AXIS; a++) begin
                check_fixed($sformatf("tri_out[%0d][%0d]", v, a), exp_tri[v][a], tri_out[v][a]);
            end
        end
        for (int k = 0; k < `RAST_COLORS; k++) begin
            check_color($sformatf("color_out[%0d]", k), exp_color[k], color_out[k]);
        end
    endtask

    // Called at a falling edge
    task automatic wait_idle(input int c);
        int waited;
        waited = 0;
        while (halt_n !== 1'b1 || sample_valid !== 1'b0) begin
            if (waited >= WAIT_LIMIT) begin
                $display("Timeout: iterator never went idle before case %0d", c);
                stop_with_failure();
            end else begin
                waited++;
                @(negedge clk);
            end
        end
    endtask

    // Called with tri_valid already driven high for the next edge
    task automatic wait_first_sample(input int c);
        int waited;
        waited = 0;
        // Edge that takes the triangle
        @(posedge clk);
        tri_valid <= 1'b0;
        @(negedge clk);
        while (sample_valid !== 1'b1) begin
            if (waited >= WAIT_LIMIT) begin
                $display("Timeout: case %0d never raised sample_valid", c);
                stop_with_failure();
            end else begin
                waited++;
                @(negedge clk);
            end
        end
        check_count($sformatf("case %0d cycles from acceptance", c), 0, waited);
    endtask

    task automatic walk_case(input int c);
        int n;
        build_walk(tab_min_x[c], tab_min_y[c], tab_max_x[c], tab_max_y[c], tab_mode[c]);
        n = exp_x.size();
        check_count($sformatf("case %0d model sample count", c), tab_cols[c] * tab_rows[c], n);
        for (int i = 0; i < n; i++) begin
            check_bit("sample_valid", 1'b1, sample_valid);
            check_bit("halt_n", 1'b0, halt_n);
            check_fixed($sformatf("sample_x[%0d]", i), exp_x[i], sample_x);
            check_fixed($sformatf("sample_y[%0d]", i), exp_y[i], sample_y);
            check_held();
            @(posedge clk);
            if (i < n - 1) begin
                disturb_inputs(i);
            end else if (c + 1 < NUM_CASES && tab_chained[c + 1]) begin
                // Next triangle lands in the first wait cycle
                present_case(c + 1);
            end else begin
                tri_valid <= 1'b0;
            end
            @(negedge clk);
        end
        // Cycle after the last sample
        check_bit("sample_valid after walk", 1'b0, sample_valid);
        check_bit("halt_n after walk", 1'b1, halt_n);
    endtask

    initial begin
        init_inputs();
        load_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // Idle after reset
        repeat (3) begin
            @(negedge clk);
            check_bit("sample_valid after reset", 1'b0, sample_valid);
            check_bit("halt_n after reset", 1'b1, halt_n);
        end
        for (int c = 0; c < NUM_CASES; c++) begin
            if (!tab_chained[c]) begin
                wait_idle(c);
                @(posedge clk);
                present_case(c);
            end
            wait_first_sample(c);
            walk_case(c);
        end
        if (checks_run > 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("No checks were run");
            stop_with_failure();
        end
    end

endmodule

//--- verilog/test_iterator.sv
// ------------------------------------------------
// Raster sample iterator top level
// Walks the box left to right and bottom to top
// The driver must hold sub_sample during a walk
// halt_n low means the upstream stage must hold
// ------------------------------------------------
`timescale 1ns/1ps
`include "raster_settings.svh"

module test_iterator (
    input  logic                    clk,
    input  logic                    rst,
    // Triangle and colour from the box stage
    input  raster_pkg::fixed_t      tri_in [`RAST_VERTS-1:0][`RAST_AXIS-1:0],
    input  raster_pkg::color_t      color_in [`RAST_COLORS-1:0],
    // Screen bounding box
    input  raster_pkg::fixed_t      box_min_x,
    input  raster_pkg::fixed_t      box_min_y,
    input  raster_pkg::fixed_t      box_max_x,
    input  raster_pkg::fixed_t      box_max_y,
    // New triangle strobe
    input  logic                    tri_valid,
    // Multisample mode
    input  raster_pkg::sub_sample_t sub_sample,
    // Held triangle and colour for the sample test
    output raster_pkg::fixed_t      tri_out [`RAST_VERTS-1:0][`RAST_AXIS-1:0],
    output raster_pkg::color_t      color_out [`RAST_COLORS-1:0],
    // Sample under test
    output raster_pkg::fixed_t      sample_x,
    output raster_pkg::fixed_t      sample_y,
    output logic                    sample_valid,
    // Upstream hold, active low
    output logic                    halt_n
);

    // Load strobe for the hold register
    logic accept;

    // Stored box seen by the stepper
    raster_pkg::fixed_t held_min_x;
    raster_pkg::fixed_t held_max_x;
    raster_pkg::fixed_t held_max_y;

    // Stepper result
    raster_pkg::fixed_t step_x;
    raster_pkg::fixed_t step_y;
    logic               box_done;

    // Walk controller
    bbox_iterator_fsm u_fsm (
        .clk          (clk),
        .rst          (rst),
        .tri_valid    (tri_valid),
        .box_min_x    (box_min_x),
        .box_min_y    (box_min_y),
        .box_max_x    (box_max_x),
        .box_max_y    (box_max_y),
        .step_x       (step_x),
        .step_y       (step_y),
        .box_done     (box_done),
        .sample_x     (sample_x),
        .sample_y     (sample_y),
        .held_min_x   (held_min_x),
        .held_max_x   (held_max_x),
        .held_max_y   (held_max_y),
        .sample_valid (sample_valid),
        .halt_n       (halt_n),
        .accept       (accept)
    );

    // Next sample and end of box
    sample_stepper u_stepper (
        .sample_x   (sample_x),
        .sample_y   (sample_y),
        .box_min_x  (held_min_x),
        .box_max_x  (held_max_x),
        .box_max_y  (held_max_y),
        .sub_sample (sub_sample),
        .step_x     (step_x),
        .step_y     (step_y),
        .box_done   (box_done)
    );

    // Triangle and colour travel beside each sample
    prim_hold_reg u_hold (
        .clk       (clk),
        .rst       (rst),
        .accept    (accept),
        .tri_in    (tri_in),
        .color_in  (color_in),
        .tri_out   (tri_out),
        .color_out (color_out)
    );

endmodule

//--- verilog/prim_hold_reg.sv
// ------------------------------------------------
// Triangle and colour hold register
// Loads on the edge after accept
// Keeps its value until the next accept
// ------------------------------------------------
`timescale 1ns/1ps
`include "raster_settings.svh"

module prim_hold_reg (
    input  logic               clk,
    input  logic               rst,
    // Load strobe from the iterator
    input  logic               accept,
    // Incoming triangle and colour
    input  raster_pkg::fixed_t tri_in [`RAST_VERTS-1:0][`RAST_AXIS-1:0],
    input  raster_pkg::color_t color_in [`RAST_COLORS-1:0],
    // Held triangle and colour
    output raster_pkg::fixed_t tri_out [`RAST_VERTS-1:0][`RAST_AXIS-1:0],
    output raster_pkg::color_t color_out [`RAST_COLORS-1:0]
);

    // Vertex coordinates
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int v = 0; v < `RAST_VERTS; v++) begin
                for (int a = 0; a < `RAST_AXIS; a++) begin
                    tri_out[v][a] <= '0;
                end
            end
        end else if (accept) begin
            for (int v = 0; v < `RAST_VERTS; v++) begin
                for (int a = 0; a < `RAST_AXIS; a++) begin
                    tri_out[v][a] <= tri_in[v][a];
                end
            end
        end
    end

    // Colour channels
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int c = 0; c < `RAST_COLORS; c++) begin
                color_out[c] <= '0;
            end
        end else if (accept) begin
            for (int c = 0; c < `RAST_COLORS; c++) begin
                color_out[c] <= color_in[c];
            end
        end
    end

endmodule

//--- verilog/bbox_iterator_fsm.sv
// ------------------------------------------------
// Bounding box walk controller
// Outputs are registered one cycle after their cause
// Inputs are ignored while a box is being walked
// No downstream stall so one sample issues per cycle
// halt_n comes out of reset high
// ------------------------------------------------
`timescale 1ns/1ps

module bbox_iterator_fsm (
    input  logic               clk,
    input  logic               rst,
    // New box strobe from upstream
    input  logic               tri_valid,
    // Incoming box corners
    input  raster_pkg::fixed_t box_min_x,
    input  raster_pkg::fixed_t box_min_y,
    input  raster_pkg::fixed_t box_max_x,
    input  raster_pkg::fixed_t box_max_y,
    // Move chosen by the stepper
    input  raster_pkg::fixed_t step_x,
    input  raster_pkg::fixed_t step_y,
    input  logic               box_done,
    // Current sample position
    output raster_pkg::fixed_t sample_x,
    output raster_pkg::fixed_t sample_y,
    // Stored box for the stepper
    output raster_pkg::fixed_t held_min_x,
    output raster_pkg::fixed_t held_max_x,
    output raster_pkg::fixed_t held_max_y,
    // Sample strobe and upstream hold
    output logic               sample_valid,
    output logic               halt_n,
    // Load strobe for the triangle hold register
    output logic               accept
);

    // Current and next iterator state
    raster_pkg::iter_state_t state;
    raster_pkg::iter_state_t next_state;

    // Next values of the registered strobes
    logic next_valid;
    logic next_halt_n;

    // Advance the sample while the walk continues
    logic advance;

    // A box is taken only while waiting
    assign accept = (state == raster_pkg::ITER_WAIT) && tri_valid;

    assign advance = (state == raster_pkg::ITER_TEST) && !box_done;

    always_comb begin
        next_state  = state;
        next_valid  = sample_valid;
        next_halt_n = halt_n;

        case (state)
            raster_pkg::ITER_WAIT: begin
                if (tri_valid) begin
                    // First sample is the lower left corner
                    next_state  = raster_pkg::ITER_TEST;
                    next_valid  = 1'b1;
                    next_halt_n = 1'b0;
                end else begin
                    // Idle with the upstream free to move
                    next_valid  = 1'b0;
                    next_halt_n = 1'b1;
                end
            end

            raster_pkg::ITER_TEST: begin
                if (box_done) begin
                    // Top right reached so release the upstream
                    next_state  = raster_pkg::ITER_WAIT;
                    next_valid  = 1'b0;
                    next_halt_n = 1'b1;
                end else begin
                    next_valid  = 1'b1;
                    next_halt_n = 1'b0;
                end
            end

            default: begin
                next_state  = raster_pkg::ITER_WAIT;
                next_valid  = 1'b0;
                next_halt_n = 1'b1;
            end
        endcase
    end

    // Control registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= raster_pkg::ITER_WAIT;
            sample_valid <= 1'b0;
            halt_n       <= 1'b1;
        end else begin
            state        <= next_state;
            sample_valid <= next_valid;
            halt_n       <= next_halt_n;
        end
    end

    // Box corners stay fixed for the whole walk
    // Min y is only needed for the first sample
    always_ff @(posedge clk) begin
        if (accept) begin
            held_min_x <= box_min_x;
            held_max_x <= box_max_x;
            held_max_y <= box_max_y;
        end
    end

    // Sample position
    always_ff @(posedge clk) begin
        if (accept) begin
            sample_x <= box_min_x;
            sample_y <= box_min_y;
        end else if (advance) begin
            sample_x <= step_x;
            sample_y <= step_y;
        end
    end

endmodule

//--- verilog/sample_stepper.sv
// ------------------------------------------------
// One walk step over the bounding box
// Pure combinational logic with no latency
// Mode must be one-hot and held for the whole walk
// Edge tests are inclusive so an off-grid max overshoots
// ------------------------------------------------
`timescale 1ns/1ps
`include "raster_settings.svh"

module sample_stepper (
    // Current sample position
    input  raster_pkg::fixed_t      sample_x,
    input  raster_pkg::fixed_t      sample_y,
    // Stored box corners
    input  raster_pkg::fixed_t      box_min_x,
    input  raster_pkg::fixed_t      box_max_x,
    input  raster_pkg::fixed_t      box_max_y,
    // Multisample mode
    input  raster_pkg::sub_sample_t sub_sample,
    // Next sample position
    output raster_pkg::fixed_t      step_x,
    output raster_pkg::fixed_t      step_y,
    // Current sample is the last one of the box
    output logic                    box_done
);

    // Sample pitch in fixed point
    raster_pkg::fixed_t pitch;

    // Candidate move one pitch to the right
    raster_pkg::fixed_t right_x;

    // Candidate move one row up
    raster_pkg::fixed_t up_y;

    // Edge flags for the current sample
    logic at_right;
    logic at_top;

    // Zero-extend the mode before shifting it into place
    assign pitch = raster_pkg::fixed_t'(sub_sample) << `RAST_STEP_SHIFT;

    // Both moves are formed every cycle
    assign right_x = sample_x + pitch;
    assign up_y    = sample_y + pitch;

    always_comb begin
        // Signed compares since corners may be negative
        at_right = (sample_x >= box_max_x);
        at_top   = (sample_y >= box_max_y);

        if (at_right) begin
            // Wrap back to the left column of the next row
            step_x = box_min_x;
            step_y = up_y;
        end else begin
            // Stay on this row
            step_x = right_x;
            step_y = sample_y;
        end

        // Last sample sits on both the right and top edge
        box_done = at_right && at_top;
    end

endmodule

//--- verilog/raster_pkg.sv
// ------------------------------------------------
// Shared types for the raster sample iterator
// Widths follow raster_settings.svh
// Positions are two's complement fixed point
// ------------------------------------------------
`include "raster_settings.svh"

package raster_pkg;

    // Signed fixed point word
    // Upper bits hold the integer part
    // Lowest RAST_RADIX bits hold the fraction
    // Used for vertices, box corners and samples
    typedef logic signed [`RAST_SIGFIG-1:0] fixed_t;

    // One unsigned colour channel
    typedef logic [`RAST_SIGFIG-1:0] color_t;

    // One-hot multisample mode
    // 4'b1000 is 1x with one pixel pitch
    // 4'b0100 is 4x with half a pixel pitch
    // 4'b0010 is 16x with a quarter pixel pitch
    // 4'b0001 is 64x with an eighth of a pixel pitch
    typedef logic [3:0] sub_sample_t;

    // Iterator states
    // Wait accepts a new box
    // Test walks the held box
    typedef enum logic {
        ITER_WAIT,
        ITER_TEST
    } iter_state_t;

endpackage

//--- verilog/raster_settings.svh
// ------------------------------------------------
// Global widths and fixed-point layout for the raster
// iterator. Every file that includes this shares them.
// Change the values only before a full recompile.
// ------------------------------------------------
`ifndef RAST_SETTINGS_SVH
`define RAST_SETTINGS_SVH

// Bits in a position or colour word
`define RAST_SIGFIG 24
// Fraction bits of a signed position
`define RAST_RADIX 10
// Vertices per triangle
`define RAST_VERTS 3
// Coordinates per vertex in x, y, z order
`define RAST_AXIS 3
// Colour channels
`define RAST_COLORS 3
// Shift from a one-hot mode onto a pitch
// Mode 4'b1000 then lands on bit RADIX, one full pixel
`define RAST_STEP_SHIFT (`RAST_RADIX - 3)
`endif
